// File: design/sseg_pkg.sv
package sseg_pkg;

    // ----------------------------------------------------------
    // sizes
    // ----------------------------------------------------------

    // operand width for x and y
    localparam int OPERAND_W = 5;

    // prescaler width, 2**4 = 16 clockin cycles per digit
    localparam int SCAN_DIV_BITS = 4;

    // ----------------------------------------------------------
    // enums
    // ----------------------------------------------------------

    // what the four digits show
    typedef enum logic [1:0] {
        MODE_DIFF = 2'd0,
        MODE_PAIR = 2'd1,
        MODE_SUM  = 2'd2
    } disp_mode_e;

    // code of one digit, decimal values plus dash and blank
    typedef enum logic [3:0] {
        DIG_0     = 4'd0,
        DIG_1     = 4'd1,
        DIG_2     = 4'd2,
        DIG_3     = 4'd3,
        DIG_4     = 4'd4,
        DIG_5     = 4'd5,
        DIG_6     = 4'd6,
        DIG_7     = 4'd7,
        DIG_8     = 4'd8,
        DIG_9     = 4'd9,
        DIG_DASH  = 4'd10,
        DIG_BLANK = 4'd15
    } digit_code_e;

    // ----------------------------------------------------------
    // structs
    // ----------------------------------------------------------

    // segment pins, all active low, dp on bit 0 like the board
    typedef struct packed {
        logic [6:0] segs;
        logic       dp;
    } sseg_frame_t;

    typedef struct packed {
        logic gt;
        logic eq;
        logic lt;
    } mag_flags_t;

    // display controls, dp_sel 0 is the rightmost digit
    typedef struct packed {
        disp_mode_e mode;
        logic       valid;
        logic       dp_en;
        logic [1:0] dp_sel;
    } disp_cfg_t;

endpackage

// File: design/mag_comp_5b.sv
`timescale 1ns/1ps

module mag_comp_5b (
    input  logic [sseg_pkg::OPERAND_W-1:0] x,
    input  logic [sseg_pkg::OPERAND_W-1:0] y,
    output sseg_pkg::mag_flags_t           flags,
    output logic [sseg_pkg::OPERAND_W-1:0] diff_mag,
    output logic [sseg_pkg::OPERAND_W:0]   sum
);
    import sseg_pkg::*;

    // x minus y with one extra bit, the top bit is the borrow
    logic [OPERAND_W:0] delta;

    assign delta = {1'b0, x} - {1'b0, y};

    // flags from the borrow and the zero test of one subtraction
    always_comb begin
        flags.lt = delta[OPERAND_W];
        flags.eq = (delta == '0);
        flags.gt = !delta[OPERAND_W] && (delta != '0);

        // larger minus smaller, never wraps
        if (flags.lt) begin
            diff_mag = y - x;
        end else begin
            diff_mag = x - y;
        end

        // one flag only, and eq agrees with a zero difference
        assert ($onehot(flags) && (flags.eq == (diff_mag == '0)))
            else $error("comparator flags inconsistent");
    end

    // one extra bit holds the carry, 31 + 31 = 62
    assign sum = {1'b0, x} + {1'b0, y};

endmodule

// File: design/bin_to_bcd.sv
`timescale 1ns/1ps

module bin_to_bcd #(
    parameter int WIDTH  = 14,
    parameter int DIGITS = 4
) (
    input  logic [WIDTH-1:0]                   value,
    output sseg_pkg::digit_code_e [DIGITS-1:0] digits
);
    import sseg_pkg::*;

    // 10 to the power pos, evaluated at elaboration for each digit
    function automatic int unsigned place_value(input int pos);
        int unsigned p;
        p = 1;
        for (int i = 0; i < pos; i++) begin
            p = p * 10;
        end
        return p;
    endfunction

    // ----------------------------------------------------------
    // successive decimal subtraction, top digit first
    // ----------------------------------------------------------
    always_comb begin
        int unsigned rem;
        int unsigned place;
        logic [3:0]  d;

        rem = 32'(value);

        for (int i = DIGITS - 1; i >= 1; i--) begin
            place = place_value(i);
            d     = 4'd0;

            // at most nine subtractions of this place value
            for (int k = 0; k < 9; k++) begin
                if (rem >= place) begin
                    rem = rem - place;
                    d   = d + 4'd1;
                end
            end

            // leading zero blanking
            // digit is dark while the whole value is below its place
            if (32'(value) < place) begin
                digits[i] = DIG_BLANK;
            end else begin
                digits[i] = digit_code_e'(d);
            end
        end

        // ones digit is whatever is left, never blanked
        digits[0] = digit_code_e'(rem[3:0]);

        // a digit is decimal or dark, never dash or an unused code
        for (int i = 0; i < DIGITS; i++) begin
            assert ((digits[i] <= DIG_9) || (digits[i] == DIG_BLANK))
                else $error("converter digit %0d out of range", i);
        end
    end

endmodule

// File: design/scan_timer.sv
`timescale 1ns/1ps

module scan_timer (
    input  logic       clockin,
    input  logic       arst_n,
    output logic [1:0] digit_idx
);
    import sseg_pkg::*;

    // free-running prescaler
    logic [SCAN_DIV_BITS-1:0] presc;
    // one cycle high when the prescaler is about to wrap
    logic                     tick;

    assign tick = &presc;

    always_ff @(posedge clockin or negedge arst_n) begin
        if (!arst_n) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // digit counter, 0 is the leftmost digit
    // ----------------------------------------------------------
    // wraps from 3 back to 0, so the scan restarts on the left
    always_ff @(posedge clockin or negedge arst_n) begin
        if (!arst_n) begin
            digit_idx <= 2'd0;
        end else if (tick) begin
            digit_idx <= digit_idx + 2'd1;
        end
    end

endmodule

// File: design/univ_sseg.sv
`timescale 1ns/1ps

module univ_sseg (
    input  logic                  clockin,
    input  logic                  arst_n,
    input  logic [13:0]           cnt_hi,
    input  logic [6:0]            cnt_lo,
    input  logic                  sign,
    input  sseg_pkg::disp_cfg_t   cfg,
    output sseg_pkg::sseg_frame_t ssegs,
    output logic [3:0]            disp_en
);
    import sseg_pkg::*;

    // converter outputs, least significant first
    digit_code_e [3:0] hi_dig;
    digit_code_e [1:0] lo_dig;
    // arranged digits, index is position from the right
    digit_code_e [3:0] arr;
    digit_code_e       cur_dig;
    logic [1:0]        digit_idx;
    logic [1:0]        pos_r;
    logic [6:0]        seg_val;
    logic              dp_on;

    bin_to_bcd #(.WIDTH(14), .DIGITS(4)) hi_conv_i (
        .value  (cnt_hi),
        .digits (hi_dig)
    );

    bin_to_bcd #(.WIDTH(7), .DIGITS(2)) lo_conv_i (
        .value  (cnt_lo),
        .digits (lo_dig)
    );

    scan_timer scan_i (
        .clockin   (clockin),
        .arst_n    (arst_n),
        .digit_idx (digit_idx)
    );

    // ----------------------------------------------------------
    // digit arrangement per mode
    // ----------------------------------------------------------
    always_comb begin
        case (cfg.mode)
            MODE_DIFF: begin
                // leftmost holds the minus sign or stays dark
                arr[3] = sign ? DIG_DASH : DIG_BLANK;
                arr[2] = hi_dig[2];
                arr[1] = hi_dig[1];
                arr[0] = hi_dig[0];
            end
            MODE_PAIR: begin
                // x on the left pair, y on the right pair
                arr[3] = hi_dig[1];
                arr[2] = hi_dig[0];
                arr[1] = lo_dig[1];
                arr[0] = lo_dig[0];
            end
            MODE_SUM: begin
                arr = hi_dig;
            end
            default: begin
                // unused mode code, show dashes
                for (int i = 0; i < 4; i++) begin
                    arr[i] = DIG_DASH;
                end
            end
        endcase
    end

    // scan index counts from the left, flip it to count from the right
    assign pos_r   = 2'd3 - digit_idx;
    assign cur_dig = arr[pos_r];
    assign dp_on   = cfg.dp_en && (cfg.dp_sel == pos_r);

    // segment decode, a..g on bits 6..0, low lights the segment
    always_comb begin
        case (cur_dig)
            DIG_0:    seg_val = 7'b0000001;
            DIG_1:    seg_val = 7'b1001111;
            DIG_2:    seg_val = 7'b0010010;
            DIG_3:    seg_val = 7'b0000110;
            DIG_4:    seg_val = 7'b1001100;
            DIG_5:    seg_val = 7'b0100100;
            DIG_6:    seg_val = 7'b0100000;
            DIG_7:    seg_val = 7'b0001111;
            DIG_8:    seg_val = 7'b0000000;
            DIG_9:    seg_val = 7'b0000100;
            DIG_DASH: seg_val = 7'b1111110;
            default:  seg_val = 7'b1111111;
        endcase
    end

    // valid low overrides everything with dashes and no dp
    always_comb begin
        if (!cfg.valid) begin
            ssegs.segs = 7'b1111110;
            ssegs.dp   = 1'b1;
        end else begin
            ssegs.segs = seg_val;
            ssegs.dp   = ~dp_on;
        end
    end

    // anode drive, bit 0 is the rightmost digit
    assign disp_en = ~(4'b0001 << pos_r);

    // one digit lit, and the scan either holds or steps one place right with wrap
    assert property (@(posedge clockin) disable iff (!arst_n)
        $onehot(~disp_en) &&
        ((disp_en == $past(disp_en)) ||
         (disp_en == {$past(disp_en[0]), $past(disp_en[3:1])})))
        else $error("anode enables not one-cold or scan order broken");

endmodule

// File: design/mag_display_top.sv
`timescale 1ns/1ps

module mag_display_top (
    input  logic                           clockin,
    input  logic                           arst_n,
    input  logic [sseg_pkg::OPERAND_W-1:0] x,
    input  logic [sseg_pkg::OPERAND_W-1:0] y,
    input  sseg_pkg::disp_cfg_t            cfg,
    output sseg_pkg::sseg_frame_t          ssegs,
    output logic [3:0]                     disp_en,
    output sseg_pkg::mag_flags_t           flags
);
    import sseg_pkg::*;

    logic [OPERAND_W-1:0] diff_mag;
    logic [OPERAND_W:0]   sum;
    // counts and sign presented to the display driver
    logic [13:0]          cnt_hi;
    logic [6:0]           cnt_lo;
    logic                 sign;

    mag_comp_5b cmp_i (
        .x        (x),
        .y        (y),
        .flags    (flags),
        .diff_mag (diff_mag),
        .sum      (sum)
    );

    // ----------------------------------------------------------
    // mode steering
    // ----------------------------------------------------------
    always_comb begin
        cnt_hi = '0;
        cnt_lo = '0;
        sign   = 1'b0;
        case (cfg.mode)
            MODE_DIFF: begin
                cnt_hi = 14'(diff_mag);
                // minus sign when x is the smaller operand
                sign   = flags.lt;
            end
            MODE_PAIR: begin
                cnt_hi = 14'(x);
                cnt_lo = 7'(y);
            end
            MODE_SUM: begin
                cnt_hi = 14'(sum);
            end
            default: begin
                cnt_hi = '0;
            end
        endcase
    end

    univ_sseg sseg_i (
        .clockin (clockin),
        .arst_n  (arst_n),
        .cnt_hi  (cnt_hi),
        .cnt_lo  (cnt_lo),
        .sign    (sign),
        .cfg     (cfg),
        .ssegs   (ssegs),
        .disp_en (disp_en)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clockin,
    output logic arst_n
);

    // 4 ns period
    initial begin
        clockin = 1'b0;
        forever #2 clockin = ~clockin;
    end

    // reset held low for two rising edges, then released on an edge
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clockin);
        arst_n <= 1'b1;
    end

endmodule

// File: test/tb_mag_display.sv
`timescale 1ns/1ps

module tb_mag_display;
    import sseg_pkg::*;

    localparam int CLK_NS       = 4;
    localparam int FRAME_CYCLES = 4 * (2 ** SCAN_DIV_BITS);
    // display scans started by all tests together, rounded up
    localparam int NUM_SCANS    = 32;
    localparam int WATCHDOG_NS  = NUM_SCANS * FRAME_CYCLES * 4 * CLK_NS;

    logic                 clockin;
    logic                 arst_n;
    logic [OPERAND_W-1:0] x;
    logic [OPERAND_W-1:0] y;
    disp_cfg_t            cfg;
    sseg_frame_t          ssegs;
    logic [3:0]           disp_en;
    mag_flags_t           flags;
    logic [31:0]          lfsr_state = 32'h1d13_6e7a;
    int                   errors = 0;
    int                   checks = 0;
    int                   tests = 0;

    tb_clock clk_i (
        .clockin (clockin),
        .arst_n  (arst_n)
    );

    mag_display_top dut_i (
        .clockin (clockin),
        .arst_n  (arst_n),
        .x       (x),
        .y       (y),
        .cfg     (cfg),
        .ssegs   (ssegs),
        .disp_en (disp_en),
        .flags   (flags)
    );

    // ----------------------------------------------------------
    // random operands, galois lfsr shifting right
    // ----------------------------------------------------------
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'hA300_0000;
        end
        return b;
    endfunction

    function automatic logic [4:0] rand_operand();
        logic [4:0] r;
        for (int i = 0; i < 5; i++) begin
            r[i] = lfsr_bit();
        end
        return r;
    endfunction

    function automatic disp_cfg_t make_cfg(disp_mode_e m, logic v, logic de, logic [1:0] ds);
        disp_cfg_t c;
        c.mode   = m;
        c.valid  = v;
        c.dp_en  = de;
        c.dp_sel = ds;
        return c;
    endfunction

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    // decimal digit at place (0 = ones), dark above the top nonzero place
    function automatic digit_code_e dec_digit(int v, int place);
        int p;
        p = (place == 0) ? 1 : (place == 1) ? 10 : (place == 2) ? 100 : 1000;
        if (place > 0 && v < p) begin
            return DIG_BLANK;
        end
        return digit_code_e'(4'((v / p) % 10));
    endfunction

    // pos counts from the right
    function automatic digit_code_e expected_digit(logic [4:0] a, logic [4:0] b,
                                                   disp_cfg_t c, int pos);
        int d;
        d = (a > b) ? int'(a - b) : int'(b - a);
        case (c.mode)
            MODE_DIFF: begin
                if (pos == 3) begin
                    return (a < b) ? DIG_DASH : DIG_BLANK;
                end
                return dec_digit(d, pos);
            end
            MODE_PAIR: begin
                if (pos >= 2) begin
                    return dec_digit(int'(a), pos - 2);
                end
                return dec_digit(int'(b), pos);
            end
            default: return dec_digit(int'(a) + int'(b), pos);
        endcase
    endfunction

    // board table, a..g high to low, 0 lights a segment
    function automatic logic [6:0] seg_of(digit_code_e d);
        case (d)
            DIG_0:    return 7'b0000001;
            DIG_1:    return 7'b1001111;
            DIG_2:    return 7'b0010010;
            DIG_3:    return 7'b0000110;
            DIG_4:    return 7'b1001100;
            DIG_5:    return 7'b0100100;
            DIG_6:    return 7'b0100000;
            DIG_7:    return 7'b0001111;
            DIG_8:    return 7'b0000000;
            DIG_9:    return 7'b0000100;
            DIG_DASH: return 7'b1111110;
            default:  return 7'b1111111;
        endcase
    endfunction

    function automatic sseg_frame_t expected_frame(logic [4:0] a, logic [4:0] b,
                                                   disp_cfg_t c, int pos);
        sseg_frame_t f;
        if (!c.valid) begin
            f.segs = 7'b1111110;
            f.dp   = 1'b1;
        end else begin
            f.segs = seg_of(expected_digit(a, b, c, pos));
            f.dp   = !(c.dp_en && (c.dp_sel == 2'(pos)));
        end
        return f;
    endfunction

    // ----------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------
    task automatic check_frame(sseg_frame_t got, sseg_frame_t exp, int pos);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: ssegs got %h expected %h at digit %0d", got, exp, pos);
        end
    endtask

    task automatic check_flags(mag_flags_t got, mag_flags_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: flags got %h expected %h for x=%h y=%h", got, exp, x, y);
        end
    endtask

    task automatic check_anodes(logic [3:0] got, logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: disp_en got %h expected %h", got, exp);
        end
    endtask

    // ----------------------------------------------------------
    // drive and sample helpers
    // ----------------------------------------------------------
    // inputs change on the rising edge, outputs are read on the falling edge
    task automatic apply(logic [4:0] a, logic [4:0] b, disp_cfg_t c);
        @(posedge clockin);
        x   <= a;
        y   <= b;
        cfg <= c;
        @(negedge clockin);
    endtask

    task automatic wait_for_anode(int pos);
        logic [3:0] want;
        int         n;
        want = ~(4'b0001 << pos);
        n = 0;
        while (disp_en !== want && n <= FRAME_CYCLES) begin
            @(negedge clockin);
            n++;
        end
        if (disp_en !== want) begin
            errors++;
            $display("anode of digit %0d was never enabled", pos);
        end
    endtask

    task automatic wait_anode_change(logic [3:0] prev);
        int n;
        n = 0;
        while (disp_en === prev && n <= 2 ** SCAN_DIV_BITS) begin
            @(negedge clockin);
            n++;
        end
        if (disp_en === prev) begin
            errors++;
            $display("scan stalled, disp_en stayed at %h", prev);
        end
    endtask

    // left to right, compare every digit of the frame
    task automatic scan_and_check();
        for (int pos = 3; pos >= 0; pos--) begin
            wait_for_anode(pos);
            check_frame(ssegs, expected_frame(x, y, cfg, pos), pos);
        end
    endtask

    task automatic finish_test(string name, int start);
        tests++;
        $display("test %s finished with %0d errors", name, errors - start);
    endtask

    // each case packs {a, b}
    task automatic run_mode(string name, disp_mode_e m, logic [9:0] cases[$]);
        int start;
        start = errors;
        foreach (cases[i]) begin
            apply(cases[i][9:5], cases[i][4:0], make_cfg(m, 1'b1, 1'b0, 2'd0));
            scan_and_check();
        end
        finish_test(name, start);
    endtask

    // ----------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------
    task automatic test_reset();
        logic [3:0] prev;
        int         start;
        start = errors;
        wait (arst_n === 1'b1);
        @(negedge clockin);
        // leftmost anode first, then one step right per tick, wrapping
        check_anodes(disp_en, 4'b0111);
        for (int k = 1; k <= 4; k++) begin
            prev = disp_en;
            wait_anode_change(prev);
            check_anodes(disp_en, ~(4'b1000 >> (k % 4)));
        end
        finish_test("reset", start);
    endtask

    task automatic test_flags();
        logic [4:0] ca [6] = '{5'd0, 5'd31, 5'd0, 5'd17, 5'd31, 5'd9};
        logic [4:0] cb [6] = '{5'd0, 5'd0, 5'd31, 5'd17, 5'd31, 5'd8};
        logic [4:0] a;
        logic [4:0] b;
        mag_flags_t want;
        int         start;
        start = errors;
        for (int i = 0; i < 26; i++) begin
            a = (i < 6) ? ca[i] : rand_operand();
            b = (i < 6) ? cb[i] : rand_operand();
            apply(a, b, make_cfg(MODE_DIFF, 1'b1, 1'b0, 2'd0));
            want.gt = (a > b);
            want.eq = (a == b);
            want.lt = (a < b);
            check_flags(flags, want);
        end
        finish_test("flags", start);
    endtask

    task automatic test_diff();
        logic [9:0] cases[$];
        cases = '{{5'd20, 5'd3}, {5'd3, 5'd20}, {5'd7, 5'd7},
                  {5'd31, 5'd0}, {5'd0, 5'd31}, {5'd12, 5'd2}};
        // a few random pairs on top of the corners
        for (int i = 0; i < 4; i++) begin
            cases.push_back({rand_operand(), rand_operand()});
        end
        run_mode("diff", MODE_DIFF, cases);
    endtask

    task automatic test_pair();
        run_mode("pair", MODE_PAIR, '{{5'd31, 5'd31}, {5'd9, 5'd10}, {5'd0, 5'd5},
                                      {5'd12, 5'd7}, {5'd3, 5'd0}});
    endtask

    task automatic test_sum();
        run_mode("sum", MODE_SUM, '{{5'd0, 5'd0}, {5'd31, 5'd31}, {5'd4, 5'd5},
                                    {5'd9, 5'd1}});
    endtask

    task automatic test_valid_dp();
        int start;
        start = errors;
        // dp requested but valid low, so dashes only
        apply(5'd13, 5'd29, make_cfg(MODE_SUM, 1'b0, 1'b1, 2'd2));
        scan_and_check();
        for (int s = 0; s < 4; s++) begin
            apply(5'd13, 5'd29, make_cfg(MODE_SUM, 1'b1, 1'b1, 2'(s)));
            scan_and_check();
        end
        finish_test("valid_dp", start);
    endtask

    // ----------------------------------------------------------
    // main sequence and watchdog
    // ----------------------------------------------------------
    initial begin
        x   = '0;
        y   = '0;
        cfg = make_cfg(MODE_DIFF, 1'b1, 1'b0, 2'd0);
        test_reset();
        test_flags();
        test_diff();
        test_pair();
        test_sum();
        test_valid_dp();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: build.f
design/sseg_pkg.sv
design/mag_comp_5b.sv
design/bin_to_bcd.sv
design/scan_timer.sv
design/univ_sseg.sv
design/mag_display_top.sv
test/tb_clock.sv
test/tb_mag_display.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run the magnitude display testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_mag_display \
    -o sim_tb > compile.log 2>&1
if [ $? -ne 0 ]; then
    cat compile.log
    echo "compile failed, see compile.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
exit 1
